// ==== list.f ====
rtl/hyper_pkg.sv
rtl/hyper_ca_gen.sv
rtl/hyper_trans_fsm.sv
rtl/hyper_cycle_counter.sv
rtl/hyper_dq_path.sv
rtl/hyper_phy_top.sv
dv/hyper_mem_model.sv
dv/tb_hyper_phy.sv

// ==== Makefile ====
# Verilator build for the HyperBus PHY testbench

VERILATOR ?= verilator
TOP       ?= tb_hyper_phy
RTL_TOP   ?= hyper_phy_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
RTL_FILES ?= rtl/hyper_pkg.sv rtl/hyper_ca_gen.sv rtl/hyper_trans_fsm.sv \
             rtl/hyper_cycle_counter.sv rtl/hyper_dq_path.sv rtl/hyper_phy_top.sv
PASS_MSG  := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_FILES) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_hyper_phy.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_hyper_phy;

    localparam int unsigned NR_CS       = 2;
    localparam int unsigned LATENCY     = 6;
    localparam int unsigned MAX_BURST   = 8;
    localparam int unsigned WORST       = 4 + 3 * LATENCY + MAX_BURST;
    localparam int unsigned N_TRANS     = 11; // transactions issued below
    localparam int unsigned CYCLE_LIMIT = N_TRANS * WORST + 100;
    localparam logic [15:0] FILL0       = 16'hA5C3;
    localparam logic [15:0] FILL1       = 16'h3C5A;

    logic                  clk0;
    logic                  rst_ni;
    logic                  trans_valid_i;
    hyper_pkg::trans_req_t trans_req_i;
    logic [NR_CS-1:0]      trans_cs_i;
    logic                  trans_ready_o;
    logic [15:0]           tx_data_i;
    logic [1:0]            tx_strb_i;
    logic                  tx_ready_o;
    logic                  rx_valid_o;
    logic [15:0]           rx_data_o;
    logic [NR_CS-1:0]      hyper_cs_no;
    logic                  hyper_ck_en_o;
    logic [15:0]           hyper_dq_o;
    logic                  hyper_dq_oe_o;
    logic [15:0]           hyper_dq_i;
    logic [1:0]            hyper_rwds_o;
    logic                  hyper_rwds_oe_o;
    logic                  hyper_rwds_i;

    logic [15:0]       m_dq [NR_CS];
    logic [NR_CS-1:0]  m_rwds;
    logic [NR_CS-1:0]  m_in_ca;
    logic [31:0]       m_addr [NR_CS];
    logic              m_rd [NR_CS];
    int unsigned       m_cnt [NR_CS];
    int unsigned       m_err [NR_CS];

    string       test_name = "init";
    int          errors = 0;
    int          err_mark;
    int          n_pass = 0;
    int          n_fail = 0;
    int unsigned cycle_cnt = 0;
    logic [15:0] shadow [NR_CS][256]; // expected device contents
    logic [15:0] rd_q [$];
    logic [15:0] wdata_q [$];
    logic [1:0]  wstrb_q [$];

    hyper_phy_top #(
        .NR_CS   ( NR_CS   ),
        .LATENCY ( LATENCY )
    ) dut_i (
        .clk0            ( clk0            ),
        .rst_ni          ( rst_ni          ),
        .trans_valid_i   ( trans_valid_i   ),
        .trans_req_i     ( trans_req_i     ),
        .trans_cs_i      ( trans_cs_i      ),
        .trans_ready_o   ( trans_ready_o   ),
        .tx_data_i       ( tx_data_i       ),
        .tx_strb_i       ( tx_strb_i       ),
        .tx_ready_o      ( tx_ready_o      ),
        .rx_valid_o      ( rx_valid_o      ),
        .rx_data_o       ( rx_data_o       ),
        .hyper_cs_no     ( hyper_cs_no     ),
        .hyper_ck_en_o   ( hyper_ck_en_o   ),
        .hyper_dq_o      ( hyper_dq_o      ),
        .hyper_dq_oe_o   ( hyper_dq_oe_o   ),
        .hyper_dq_i      ( hyper_dq_i      ),
        .hyper_rwds_o    ( hyper_rwds_o    ),
        .hyper_rwds_oe_o ( hyper_rwds_oe_o ),
        .hyper_rwds_i    ( hyper_rwds_i    )
    );

    for (genvar g = 0; g < NR_CS; g++) begin : g_mem
        hyper_mem_model #(
            .LATENCY  ( LATENCY                   ),
            .FILL_XOR ( (g == 0) ? FILL0 : FILL1  )
        ) u_mem (
            .clk0      ( clk0            ),
            .cs_ni     ( hyper_cs_no[g]  ),
            .dq_i      ( hyper_dq_o      ),
            .dq_oe_i   ( hyper_dq_oe_o   ),
            .rwds_i    ( hyper_rwds_o    ),
            .rwds_oe_i ( hyper_rwds_oe_o ),
            .dq_o      ( m_dq[g]         ),
            .rwds_o    ( m_rwds[g]       ),
            .in_ca_o   ( m_in_ca[g]      ),
            .addr_o    ( m_addr[g]       ),
            .rd_o      ( m_rd[g]         ),
            .n_trans_o ( m_cnt[g]        ),
            .ca_err_o  ( m_err[g]        )
        );
    end

    assign hyper_dq_i   = m_dq[0] | m_dq[1];  // idle device drives zero
    assign hyper_rwds_i = |m_rwds;

    initial begin
        clk0 = 1'b0;
        forever #2 clk0 = ~clk0;
    end

    always @(posedge clk0) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: no end of run after %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    a_reset_quiet: assert property (@(posedge clk0) !rst_ni |->
        (hyper_cs_no == '1) && !trans_ready_o && !tx_ready_o && !rx_valid_o &&
        !hyper_dq_oe_o && !hyper_rwds_oe_o && !hyper_ck_en_o)
    else begin
        $display("[ERROR] %s: outputs not idle while reset is held", test_name);
        errors++;
    end

    a_cs_single: assert property (@(posedge clk0) disable iff (!rst_ni)
        $countones(~hyper_cs_no) <= 1)
    else begin
        $display("[ERROR] %s: more than one chip select low", test_name);
        errors++;
    end

    // clock runs exactly while a device is selected
    a_cs_clock: assert property (@(posedge clk0) disable iff (!rst_ni)
        (hyper_cs_no != '1) == hyper_ck_en_o)
    else begin
        $display("[ERROR] %s: clock enable does not match chip select", test_name);
        errors++;
    end

    a_cs_steer: assert property (@(posedge clk0) disable iff (!rst_ni)
        (hyper_cs_no != '1) |-> (~hyper_cs_no == trans_cs_i))
    else begin
        $display("[ERROR] %s: wrong chip select driven low", test_name);
        errors++;
    end

    a_dq_oe: assert property (@(posedge clk0) disable iff (!rst_ni)
        hyper_dq_oe_o == ((|m_in_ca) || hyper_rwds_oe_o))
    else begin
        $display("[ERROR] %s: dq output enable outside command or write beats", test_name);
        errors++;
    end

    a_tx_window: assert property (@(posedge clk0) disable iff (!rst_ni)
        tx_ready_o |-> hyper_ck_en_o)
    else begin
        $display("[ERROR] %s: write data fetched outside a transaction", test_name);
        errors++;
    end

    function automatic logic [15:0] fill_word(int unsigned cs, int unsigned k);
        return (16'(k) * 16'h0101) ^ ((cs == 0) ? FILL0 : FILL1);
    endfunction

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic finish_test();
        if (errors == err_mark) begin
            $display("test %s: passed", test_name);
            n_pass++;
        end else begin
            $display("test %s: failed with %0d errors", test_name, errors - err_mark);
            n_fail++;
        end
    endtask

    // one transaction from falling edge to falling edge
    task automatic run_trans(input int unsigned cs, input logic [31:0] addr, input logic wr,
                             input int unsigned len, input bit hold);
        int unsigned cyc;
        int unsigned sent;
        rd_q.delete();
        trans_req_i.addr  = addr;
        trans_req_i.write = wr;
        trans_req_i.burst = len[hyper_pkg::BURST_W-1:0];
        trans_cs_i        = '0;
        trans_cs_i[cs]    = 1'b1;
        trans_valid_i     = 1'b1;
        while (!trans_ready_o) @(negedge clk0);
        @(negedge clk0); // accepted on the edge just passed
        if (!hold) trans_valid_i = 1'b0;
        cyc  = 1;
        sent = 0;
        while (!trans_ready_o) begin
            if (tx_ready_o) begin
                if (sent < wdata_q.size()) begin
                    tx_data_i = wdata_q[sent];
                    tx_strb_i = wstrb_q[sent];
                end else begin
                    $display("[ERROR] %s: write word requested past the burst end", test_name);
                    errors++;
                end
                sent++;
            end
            if (rx_valid_o) rd_q.push_back(rx_data_o);
            @(negedge clk0);
            cyc++;
        end
        expect_eq("accept to ready cycles", 1 + 3 + 3 * LATENCY + len, cyc);
        if (wr) expect_eq("write words fetched", len, sent);
    endtask

    task automatic check_read(input int unsigned cs, input logic [31:0] a, input int unsigned n);
        logic [7:0] idx;
        expect_eq("read strobes", n, rd_q.size());
        for (int unsigned i = 0; i < n && i < rd_q.size(); i++) begin
            idx = a[7:0] + 8'(i);
            expect_eq("read word", {16'h0, shadow[cs][idx]}, {16'h0, rd_q[i]});
        end
    endtask

    task automatic write_random(input int unsigned cs, input logic [31:0] a,
                                input int unsigned n, input bit hold);
        logic [7:0] idx;
        wdata_q.delete();
        wstrb_q.delete();
        for (int unsigned i = 0; i < n; i++) begin
            wdata_q.push_back(16'($urandom));
            wstrb_q.push_back(2'($urandom));
        end
        run_trans(cs, a, 1'b1, n, hold);
        for (int unsigned i = 0; i < n; i++) begin
            idx = a[7:0] + 8'(i);
            if (wstrb_q[i][1]) shadow[cs][idx][15:8] = wdata_q[i][15:8];
            if (wstrb_q[i][0]) shadow[cs][idx][7:0] = wdata_q[i][7:0];
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        int unsigned n;
        int unsigned c0;
        int unsigned c1;
        void'($urandom(32'h154f30d6));
        rst_ni        = 1'b1;
        trans_valid_i = 1'b0;
        trans_req_i   = '0;
        trans_cs_i    = '0;
        tx_data_i     = 16'h0;
        tx_strb_i     = 2'b00;
        for (int unsigned c = 0; c < NR_CS; c++) begin
            for (int unsigned k = 0; k < 256; k++) begin
                shadow[c][k] = fill_word(c, k);
            end
        end

        start_test("reset");
        #1;
        rst_ni = 1'b0; // reset lands before the first rising edge
        repeat (4) @(negedge clk0);
        rst_ni = 1'b1;
        @(negedge clk0);
        expect_eq("chip selects", {NR_CS{1'b1}}, hyper_cs_no);
        expect_eq("clock enable", 0, hyper_ck_en_o);
        expect_eq("dq output enable", 0, hyper_dq_oe_o);
        expect_eq("tx ready", 0, tx_ready_o);
        expect_eq("rx valid", 0, rx_valid_o);
        expect_eq("ready in standby", 1, trans_ready_o);
        finish_test();

        start_test("ca_decode");
        a = $urandom;
        run_trans(0, a, 1'b0, 2, 1'b0);
        expect_eq("decoded address", a, m_addr[0]);
        expect_eq("read bit", 1, m_rd[0]);
        a = $urandom;
        write_random(0, a, 1, 1'b0);
        expect_eq("decoded address", a, m_addr[0]);
        expect_eq("read bit", 0, m_rd[0]);
        expect_eq("beat errors", 0, m_err[0]);
        finish_test();

        start_test("read_burst");
        repeat (2) begin
            a = $urandom;
            n = 1 + ($urandom % MAX_BURST);
            run_trans(0, a, 1'b0, n, 1'b0);
            check_read(0, a, n);
        end
        finish_test();

        start_test("masked_write");
        a = $urandom;
        n = 1 + ($urandom % MAX_BURST);
        write_random(0, a, n, 1'b0);
        run_trans(0, a, 1'b0, n, 1'b0);
        check_read(0, a, n);
        finish_test();

        start_test("cs_steering");
        c0 = m_cnt[0];
        c1 = m_cnt[1];
        a  = $urandom;
        n  = 1 + ($urandom % MAX_BURST);
        run_trans(1, a, 1'b0, n, 1'b0);
        check_read(1, a, n);
        expect_eq("cs0 transactions", c0, m_cnt[0]);
        expect_eq("cs1 transactions", c1 + 1, m_cnt[1]);
        write_random(1, a, n, 1'b0);
        expect_eq("cs0 transactions", c0, m_cnt[0]);
        expect_eq("cs1 transactions", c1 + 2, m_cnt[1]);
        finish_test();

        start_test("back_to_back");
        c0 = m_cnt[0] + m_cnt[1];
        a  = $urandom;
        b  = $urandom;
        run_trans(0, a, 1'b0, MAX_BURST, 1'b1);  // valid stays high throughout
        check_read(0, a, MAX_BURST);
        write_random(1, b, 3, 1'b1);
        run_trans(1, b, 1'b0, 3, 1'b0);
        check_read(1, b, 3);
        expect_eq("transactions seen", c0 + 3, m_cnt[0] + m_cnt[1]);
        expect_eq("beat errors", 0, m_err[0] + m_err[1]);
        finish_test();

        $display("tests passed %0d failed %0d, errors %0d", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/hyper_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module hyper_mem_model #(
    parameter int unsigned LATENCY  = 6,
    parameter logic [15:0] FILL_XOR = 16'hA5C3
) (
    input  logic        clk0,
    input  logic        cs_ni,
    input  logic [15:0] dq_i,
    input  logic        dq_oe_i,
    input  logic [1:0]  rwds_i,      // high byte mask in bit 1
    input  logic        rwds_oe_i,
    output logic [15:0] dq_o,
    output logic        rwds_o,
    output logic        in_ca_o,     // command-address beat on the bus now
    output logic [31:0] addr_o,      // last decoded word address
    output logic        rd_o,
    output int unsigned n_trans_o,
    output int unsigned ca_err_o
);

    logic [15:0] mem [256];
    logic [47:0] ca_q;
    logic [1:0]  beat_q;
    int unsigned lat_q;
    logic [7:0]  ptr_q;

    initial begin
        for (int k = 0; k < 256; k++) begin
            mem[k] = (16'(k) * 16'h0101) ^ FILL_XOR;
        end
        beat_q    = 2'd0;
        lat_q     = 0;
        ptr_q     = 8'd0;
        dq_o      = 16'h0;
        rwds_o    = 1'b0;
        addr_o    = 32'h0;
        rd_o      = 1'b0;
        n_trans_o = 0;
        ca_err_o  = 0;
    end

    assign in_ca_o = !cs_ni && (beat_q != 2'd3);

    always @(posedge clk0) begin
        if (cs_ni) begin
            beat_q <= 2'd0;
            lat_q  <= 0;
            dq_o   <= 16'h0;
            rwds_o <= 1'b0;
        end else if (beat_q != 2'd3) begin
            case (beat_q)
                2'd0: ca_q[47:32] <= dq_i;   // rw, space, burst type first
                2'd1: ca_q[31:16] <= dq_i;
                default: ca_q[15:0] <= dq_i;
            endcase
            if (!dq_oe_i) begin
                ca_err_o <= ca_err_o + 1;
            end
            beat_q <= beat_q + 2'd1;
        end else begin
            if (lat_q == 0) begin
                // decode the field view of the command-address word
                rd_o      <= ca_q[47];
                addr_o    <= {ca_q[44:16], ca_q[2:0]};
                ptr_q     <= {ca_q[20:16], ca_q[2:0]};
                n_trans_o <= n_trans_o + 1;
                if (ca_q[46] || !ca_q[45] || (ca_q[15:3] != 13'h0)) begin
                    ca_err_o <= ca_err_o + 1;
                end
            end
            if (lat_q < 2 * LATENCY) begin
                lat_q <= lat_q + 1;
            end
            // read word visible in the cycle after this edge
            if ((lat_q >= 2 * LATENCY - 1) && (lat_q != 0) && rd_o) begin
                dq_o   <= mem[ptr_q];
                rwds_o <= 1'b1;
                ptr_q  <= ptr_q + 8'd1;
            end
            if ((lat_q == 2 * LATENCY) && !rd_o && rwds_oe_i) begin
                if (!rwds_i[1]) mem[ptr_q][15:8] <= dq_i[15:8];
                if (!rwds_i[0]) mem[ptr_q][7:0] <= dq_i[7:0];
                ptr_q <= ptr_q + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hyper_phy_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module hyper_phy_top #(
    parameter int unsigned NR_CS   = 2,
    parameter int unsigned LATENCY = 6
) (
    input  logic                  clk0,
    input  logic                  rst_ni,
    // transactions
    input  logic                  trans_valid_i,
    input  hyper_pkg::trans_req_t trans_req_i,
    input  logic [NR_CS-1:0]      trans_cs_i,
    output logic                  trans_ready_o,
    // transmit channel
    input  logic [15:0]           tx_data_i,
    input  logic [1:0]            tx_strb_i,
    output logic                  tx_ready_o,
    // receive channel
    output logic                  rx_valid_o,
    output logic [15:0]           rx_data_o,
    // physical interface, clock gate lives in the pad ring
    output logic [NR_CS-1:0]      hyper_cs_no,
    output logic                  hyper_ck_en_o,
    output logic [15:0]           hyper_dq_o,
    output logic                  hyper_dq_oe_o,
    input  logic [15:0]           hyper_dq_i,
    output logic [1:0]            hyper_rwds_o,
    output logic                  hyper_rwds_oe_o,
    input  logic                  hyper_rwds_i
);

    hyper_pkg::cnt_cmd_t   cnt_cmd;
    hyper_pkg::cnt_stat_t  cnt_stat;
    hyper_pkg::phy_ctrl_t  ctrl;
    hyper_pkg::trans_req_t req_lat;
    logic [15:0]           ca_beat;

    hyper_trans_fsm #(
        .NR_CS   ( NR_CS   ),
        .LATENCY ( LATENCY )
    ) u_fsm (
        .clk0          ( clk0          ),
        .rst_ni        ( rst_ni        ),
        .trans_valid_i ( trans_valid_i ),
        .trans_req_i   ( trans_req_i   ),
        .trans_cs_i    ( trans_cs_i    ),
        .trans_ready_o ( trans_ready_o ),
        .stat_i        ( cnt_stat      ),
        .cnt_cmd_o     ( cnt_cmd       ),
        .ctrl_o        ( ctrl          ),
        .req_o         ( req_lat       ),
        .hyper_cs_no   ( hyper_cs_no   )
    );

    hyper_cycle_counter #(
        .LATENCY ( LATENCY )
    ) u_cnt (
        .clk0   ( clk0     ),
        .rst_ni ( rst_ni   ),
        .cmd_i  ( cnt_cmd  ),
        .stat_o ( cnt_stat )
    );

    hyper_ca_gen u_ca (
        .req_i      ( req_lat       ),
        .beat_sel_i ( ctrl.beat_sel ),
        .beat_o     ( ca_beat       )
    );

    hyper_dq_path u_dq (
        .clk0            ( clk0            ),
        .rst_ni          ( rst_ni          ),
        .ctrl_i          ( ctrl            ),
        .ca_beat_i       ( ca_beat         ),
        .tx_data_i       ( tx_data_i       ),
        .tx_strb_i       ( tx_strb_i       ),
        .tx_ready_o      ( tx_ready_o      ),
        .rx_valid_o      ( rx_valid_o      ),
        .rx_data_o       ( rx_data_o       ),
        .hyper_dq_o      ( hyper_dq_o      ),
        .hyper_dq_oe_o   ( hyper_dq_oe_o   ),
        .hyper_rwds_o    ( hyper_rwds_o    ),
        .hyper_rwds_oe_o ( hyper_rwds_oe_o ),
        .hyper_dq_i      ( hyper_dq_i      ),
        .hyper_rwds_i    ( hyper_rwds_i    ),
        .hyper_ck_en_o   ( hyper_ck_en_o   )
    );

endmodule

`default_nettype wire

// ==== rtl/hyper_dq_path.sv ====
`timescale 1ns/10ps
`default_nettype none

module hyper_dq_path (
    input  logic                 clk0,
    input  logic                 rst_ni,
    input  hyper_pkg::phy_ctrl_t ctrl_i,
    input  logic [15:0]          ca_beat_i,
    // write data from the host
    input  logic [15:0]          tx_data_i,
    input  logic [1:0]           tx_strb_i,   // 1 = byte written
    output logic                 tx_ready_o,
    // read data to the host
    output logic                 rx_valid_o,
    output logic [15:0]          rx_data_o,
    // bus side, one word per cycle, high byte is the first half
    output logic [15:0]          hyper_dq_o,
    output logic                 hyper_dq_oe_o,
    output logic [1:0]           hyper_rwds_o, // mask per byte half
    output logic                 hyper_rwds_oe_o,
    input  logic [15:0]          hyper_dq_i,
    input  logic                 hyper_rwds_i,
    output logic                 hyper_ck_en_o
);

    logic        wr_act_q;  // current cycle drives a write word
    logic [15:0] tx_word_q;
    logic [1:0]  mask_q;
    logic        rd_hit;

    assign tx_ready_o = ctrl_i.wr_win;
    assign rd_hit     = ctrl_i.rd_win & hyper_rwds_i; // device marks valid words

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_act_q   <= 1'b0;
            rx_valid_o <= 1'b0;
        end else begin
            wr_act_q   <= ctrl_i.wr_win;
            rx_valid_o <= rd_hit;
        end
    end

    // write word held for exactly one bus cycle
    always_ff @(posedge clk0) begin
        if (ctrl_i.wr_win) begin
            tx_word_q <= tx_data_i;
            mask_q    <= ~tx_strb_i; // rwds high masks the byte
        end
    end

    always_ff @(posedge clk0) begin
        if (rd_hit) begin
            rx_data_o <= hyper_dq_i;
        end
    end

    // dq source: write word, then command beats, otherwise quiet
    always_comb begin
        hyper_dq_o = '0;
        if (wr_act_q) begin
            hyper_dq_o = tx_word_q;
        end else if (ctrl_i.dq_oe) begin
            hyper_dq_o = ca_beat_i;
        end
    end

    assign hyper_dq_oe_o   = ctrl_i.dq_oe;
    assign hyper_rwds_o    = wr_act_q ? mask_q : 2'b00;
    assign hyper_rwds_oe_o = wr_act_q; // device owns rwds outside write data
    assign hyper_ck_en_o   = ctrl_i.ck_en;

endmodule

`default_nettype wire

// ==== rtl/hyper_cycle_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module hyper_cycle_counter #(
    parameter int unsigned LATENCY = 6
) (
    input  logic                 clk0,
    input  logic                 rst_ni,
    input  hyper_pkg::cnt_cmd_t  cmd_i,
    output hyper_pkg::cnt_stat_t stat_o
);

    localparam int unsigned WAIT_W = (LATENCY > 0) ? $clog2(2 * LATENCY) : 1;
    localparam logic [WAIT_W-1:0] LAT_LOAD = WAIT_W'(2 * LATENCY - 1); // doubled latency
    localparam logic [WAIT_W-1:0] REC_LOAD = WAIT_W'(LATENCY - 1);     // cs high time

    logic [WAIT_W-1:0]             wait_q;
    logic [WAIT_W-1:0]             wait_d;
    logic [hyper_pkg::BURST_W-1:0] burst_q;
    logic [hyper_pkg::BURST_W-1:0] burst_d;

    always_comb begin
        wait_d = wait_q;
        if (cmd_i.load_lat) begin
            wait_d = LAT_LOAD;
        end else if (cmd_i.load_rec) begin
            wait_d = REC_LOAD;
        end else if (wait_q != '0) begin
            wait_d = wait_q - 1'b1;
        end
    end

    always_comb begin
        burst_d = burst_q;
        if (cmd_i.load_burst) begin
            burst_d = cmd_i.burst - 1'b1;
        end else if (burst_q != '0) begin
            burst_d = burst_q - 1'b1;
        end
    end

    // flags follow the count into the same cycle
    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wait_q            <= '0;
            burst_q           <= '0;
            stat_o.wait_done  <= 1'b0;
            stat_o.burst_last <= 1'b0;
        end else begin
            wait_q            <= wait_d;
            burst_q           <= burst_d;
            stat_o.wait_done  <= (wait_d == '0);
            stat_o.burst_last <= (burst_d == '0);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hyper_trans_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module hyper_trans_fsm #(
    parameter int unsigned NR_CS   = 2,
    parameter int unsigned LATENCY = 6
) (
    input  logic                  clk0,
    input  logic                  rst_ni,
    input  logic                  trans_valid_i,
    input  hyper_pkg::trans_req_t trans_req_i,
    input  logic [NR_CS-1:0]      trans_cs_i,
    output logic                  trans_ready_o,
    input  hyper_pkg::cnt_stat_t  stat_i,
    output hyper_pkg::cnt_cmd_t   cnt_cmd_o,
    output hyper_pkg::phy_ctrl_t  ctrl_o,
    output hyper_pkg::trans_req_t req_o,
    output logic [NR_CS-1:0]      hyper_cs_no
);

    // zero latency skips the wait and recovery phases
    localparam bit NO_LAT = (LATENCY == 0);

    hyper_pkg::fsm_state_e state_q;
    hyper_pkg::fsm_state_e state_d;
    hyper_pkg::fsm_state_e data_st;
    hyper_pkg::trans_req_t req_q;
    logic [NR_CS-1:0]      cs_q;
    logic [NR_CS-1:0]      cs_sel;
    logic [1:0]            beat_q;
    logic                  accept;

    function automatic logic bus_active(hyper_pkg::fsm_state_e st);
        return st inside {hyper_pkg::CMD_ADDR, hyper_pkg::LATENCY,
                          hyper_pkg::DATA_R, hyper_pkg::DATA_W};
    endfunction

    assign accept  = trans_valid_i & trans_ready_o; // ready is only up in standby
    assign data_st = req_q.write ? hyper_pkg::DATA_W : hyper_pkg::DATA_R;
    assign cs_sel  = accept ? trans_cs_i : cs_q;
    assign req_o   = req_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            hyper_pkg::STANDBY: begin
                if (accept) begin
                    state_d = hyper_pkg::CMD_ADDR;
                end
            end
            hyper_pkg::CMD_ADDR: begin
                if (beat_q == 2'd2) begin
                    state_d = NO_LAT ? data_st : hyper_pkg::LATENCY;
                end
            end
            hyper_pkg::LATENCY: begin
                if (stat_i.wait_done) begin
                    state_d = data_st;
                end
            end
            hyper_pkg::DATA_R, hyper_pkg::DATA_W: begin
                if (stat_i.burst_last) begin
                    state_d = NO_LAT ? hyper_pkg::STANDBY : hyper_pkg::RECOVER;
                end
            end
            hyper_pkg::RECOVER: begin
                if (stat_i.wait_done) begin
                    state_d = hyper_pkg::STANDBY;
                end
            end
            default: begin
                state_d = hyper_pkg::STANDBY;
            end
        endcase
    end

    // counter loads fire on the cycle before a phase starts
    always_comb begin
        cnt_cmd_o          = '0;
        cnt_cmd_o.burst    = req_q.burst;
        cnt_cmd_o.load_lat = (state_d == hyper_pkg::LATENCY) &&
                             (state_q != hyper_pkg::LATENCY);
        cnt_cmd_o.load_rec = (state_d == hyper_pkg::RECOVER) &&
                             (state_q != hyper_pkg::RECOVER);
        cnt_cmd_o.load_burst = (state_d inside {hyper_pkg::DATA_R, hyper_pkg::DATA_W}) &&
                               !(state_q inside {hyper_pkg::DATA_R, hyper_pkg::DATA_W});
    end

    always_comb begin
        ctrl_o          = '0;
        ctrl_o.beat_sel = beat_q;
        ctrl_o.dq_oe    = (state_q == hyper_pkg::CMD_ADDR) ||
                          (state_q == hyper_pkg::DATA_W);
        ctrl_o.rd_win   = (state_q == hyper_pkg::DATA_R);
        ctrl_o.wr_win   = (state_d == hyper_pkg::DATA_W); // fetch one word ahead
        ctrl_o.ck_en    = bus_active(state_q);
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= hyper_pkg::STANDBY;
            beat_q        <= 2'd0;
            trans_ready_o <= 1'b0;
            hyper_cs_no   <= '1;
        end else begin
            state_q       <= state_d;
            trans_ready_o <= (state_d == hyper_pkg::STANDBY);
            // cs tracks the bus phases, released during recovery
            hyper_cs_no   <= bus_active(state_d) ? ~cs_sel : '1;
            if ((state_q == hyper_pkg::CMD_ADDR) && (state_d == hyper_pkg::CMD_ADDR)) begin
                beat_q <= beat_q + 2'd1;
            end else begin
                beat_q <= 2'd0;
            end
        end
    end

    // local copy of the accepted transaction
    always_ff @(posedge clk0) begin
        if (accept) begin
            req_q <= trans_req_i;
            cs_q  <= trans_cs_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hyper_ca_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module hyper_ca_gen (
    input  hyper_pkg::trans_req_t req_i,
    input  logic [1:0]            beat_sel_i,
    output logic [15:0]           beat_o
);

    hyper_pkg::ca_word_u ca;

    // field view, filled from the latched request
    always_comb begin
        ca              = '0;
        ca.f.rw         = ~req_i.write;
        ca.f.addr_space = 1'b0;
        ca.f.burst_type = 1'b1;          // linear bursts only
        ca.f.addr_hi    = req_i.addr[31:3];
        ca.f.rsvd       = '0;
        ca.f.addr_lo    = req_i.addr[2:0]; // word within the page
    end

    // beat view, most significant beat first
    always_comb begin
        case (beat_sel_i)
            2'd0: begin
                beat_o = ca.beat[2];
            end
            2'd1: begin
                beat_o = ca.beat[1];
            end
            2'd2: begin
                beat_o = ca.beat[0];
            end
            default: begin
                beat_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/hyper_pkg.sv ====
`default_nettype none

package hyper_pkg;

    // width of the burst length field, n means n words
    localparam int unsigned BURST_W = 12;

    // one host transaction, chip select travels beside it
    typedef struct packed {
        logic [31:0]        addr;   // word address
        logic               write;
        logic [BURST_W-1:0] burst;
    } trans_req_t;

    // 48-bit command-address word, seen as fields or as bus beats
    typedef union packed {
        struct packed {
            logic        rw;         // 1 = read
            logic        addr_space; // 0 = memory array
            logic        burst_type; // 1 = linear
            logic [28:0] addr_hi;
            logic [12:0] rsvd;
            logic [2:0]  addr_lo;
        } f;
        logic [2:0][15:0] beat;      // beat[2] goes out first
    } ca_word_u;

    typedef enum logic [2:0] {
        STANDBY,
        CMD_ADDR,
        LATENCY,
        DATA_R,
        DATA_W,
        RECOVER
    } fsm_state_e;

    // fsm to data path
    typedef struct packed {
        logic [1:0] beat_sel; // command-address beat on the bus
        logic       dq_oe;
        logic       rd_win;   // current cycle is a read data cycle
        logic       wr_win;   // next cycle is a write data cycle
        logic       ck_en;
    } phy_ctrl_t;

    // fsm to cycle counter
    typedef struct packed {
        logic               load_lat;
        logic               load_rec;
        logic               load_burst;
        logic [BURST_W-1:0] burst;
    } cnt_cmd_t;

    // cycle counter back to fsm
    typedef struct packed {
        logic wait_done;
        logic burst_last;
    } cnt_stat_t;

endpackage

`default_nettype wire
